/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        := tb_sdrc_mgmt
FILELIST   := all.f
OBJ_DIR    := obj_dir
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+source
source/sdrc_pkg.sv
source/sdrc_init_fsm.sv
source/sdrc_mgmt_timer.sv
source/sdrc_cmd_arb.sv
source/sdrc_sdr_io.sv
source/sdrc_mgmt_top.sv
dv/sdrc_cmd_model.sv
dv/tb_sdrc_mgmt.sv

/* dv/sdrc_cmd_model.sv */
// SDRAM pin monitor and reference model of the expected command stream
`include "sdrc_cfg.svh"

module sdrc_cmd_model (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            i_tras_ok,
   input  logic [`SDR_DLY_W-1:0]           i_trp,
   input  logic [`SDR_DLY_W-1:0]           i_trcar,
   input  logic [`SDR_ADDR_W-1:0]          i_mode_reg,
   input  logic [`SDR_RFSH_ROW_CNT_W-1:0]  i_rfsh_rmax,
   input  sdrc_pkg::bank_req_t             i_b2x,
   input  logic                            i_x2b_ack,
   input  logic                            i_refresh,
   input  logic                            i_act_ok,
   input  logic                            i_init_done,
   input  logic                            i_sdr_cs_n,
   input  logic                            i_sdr_ras_n,
   input  logic                            i_sdr_cas_n,
   input  logic                            i_sdr_we_n,
   input  logic [`SDR_BA_W-1:0]            i_sdr_ba,
   input  logic [`SDR_ADDR_W-1:0]          i_sdr_addr,
   output int                              o_n_err,
   output int                              o_n_refresh,
   output int                              o_n_mode,
   output int                              o_n_round,
   output int                              o_n_bank,
   output int                              o_round_refs
);
   timeunit 1ns;
   timeprecision 1ps;
   import sdrc_pkg::*;

   sdr_cmd_t  exp_cmd;                          // bank command due next cycle
   logic      exp_valid, tras_d, refresh_d, act_d, init_d;
   logic      round_periodic, busy;             // busy while a refresh round runs
   sdr_cmd_e  pin_cmd, last_mgmt;
   int        cyc, last_cyc, mode_cyc, round_exp;

   assign pin_cmd = sdr_cmd_e'({i_sdr_cs_n, i_sdr_ras_n, i_sdr_cas_n, i_sdr_we_n});

   task automatic check_val(input string sig, input int got, input int exp);
      assert (got == exp) else begin
         $display("ERR t=%0t %s got=%0h exp=%0h", $time, sig, got, exp);
         o_n_err++;
      end
   endtask

   // pins are sampled mid-cycle, well away from the registering edge
   always @(negedge clk) begin
      if (!reset_n) begin
         {exp_valid, tras_d, refresh_d, act_d, init_d, round_periodic, busy} = '0;
         exp_cmd = '0;
         last_mgmt = DESEL;
         {cyc, last_cyc, mode_cyc, round_exp} = '0;
         {o_n_err, o_n_refresh, o_n_mode, o_n_round, o_n_bank, o_round_refs} = '0;
      end else begin
         cyc++;
         if (exp_valid) begin                     // acked one cycle ago
            check_val("pin_cmd", pin_cmd, exp_cmd.cmd);
            check_val("o_sdr_ba", i_sdr_ba, exp_cmd.ba);
            check_val("o_sdr_addr", i_sdr_addr, exp_cmd.addr);
            o_n_bank++;
         end else begin
            assert (pin_cmd inside {DESEL, NOP, PRECHARGE, REFRESH, MODE}) else begin
               $display("bank command on the pins at t=%0t without an ack", $time);
               o_n_err++;
            end
            case (pin_cmd)
               PRECHARGE: begin
                  assert (tras_d) else begin
                     $display("precharge all issued at t=%0t while tras_ok was low", $time);
                     o_n_err++;
                  end
                  check_val("o_sdr_addr", i_sdr_addr, `SDR_PRE_ALL_ADDR);
                  if (round_periodic)
                     check_val("round_refs", o_round_refs, i_rfsh_rmax); // previous round
                  round_periodic = i_init_done;
                  round_exp      = i_init_done ? int'(i_rfsh_rmax) : 15;
                  o_round_refs   = 0;
                  busy           = 1'b1;
                  last_mgmt      = PRECHARGE;
                  last_cyc       = cyc;
                  if (i_init_done)
                     o_n_round++;
               end
               REFRESH: begin
                  check_val("refresh_spacing", cyc - last_cyc,
                            (last_mgmt == PRECHARGE) ? i_trp + 2 : i_trcar + 2);
                  o_round_refs++;
                  assert (o_round_refs <= round_exp) else begin
                     $display("more refreshes than expected in a round at t=%0t", $time);
                     o_n_err++;
                  end
                  o_n_refresh++;
                  last_mgmt = REFRESH;
                  last_cyc  = cyc;
               end
               MODE: begin
                  check_val("mode_spacing", cyc - last_cyc, i_trcar + 2);
                  check_val("init_refreshes", o_round_refs, 15);
                  check_val("o_sdr_addr", i_sdr_addr, i_mode_reg);
                  check_val("o_sdr_ba", i_sdr_ba, {1'b0, i_mode_reg[11]});
                  mode_cyc       = cyc;
                  round_periodic = 1'b0;
                  last_mgmt      = MODE;
                  o_n_mode++;
               end
               default: ;
            endcase
         end
         if (busy && o_round_refs == round_exp && cyc >= last_cyc + i_trcar + 1)
            busy = 1'b0;                          // sequencer back in ACTIVE
         assert (!(i_x2b_ack && busy)) else begin
            $display("bank request acked during a refresh round at t=%0t", $time);
            o_n_err++;
         end
         check_val("o_refresh", refresh_d, pin_cmd == REFRESH);
         check_val("o_act_ok", i_act_ok, !(pin_cmd == ACTIVATE || act_d));
         if (i_init_done && !init_d)
            check_val("init_done_delay", cyc - mode_cyc, `SDR_TMRD + 2);
         tras_d    = i_tras_ok;
         refresh_d = i_refresh;
         act_d     = (pin_cmd == ACTIVATE);
         init_d    = i_init_done;
         exp_valid = i_x2b_ack;
         exp_cmd.ba   = i_b2x.ba;
         exp_cmd.addr = i_b2x.addr;
         case (i_b2x.op)                          // opcode to pin pattern
            OP_PRE:  exp_cmd.cmd = PRECHARGE;
            OP_ACT:  exp_cmd.cmd = ACTIVATE;
            OP_RD:   exp_cmd.cmd = READ;
            default: exp_cmd.cmd = WRITE;
         endcase
      end
   end

endmodule

/* dv/tb_sdrc_mgmt.sv */
// testbench for the SDRAM init/refresh controller with seeded random requests
`include "sdrc_cfg.svh"

module tb_sdrc_mgmt;
   timeunit 1ns;
   timeprecision 1ps;
   import sdrc_pkg::*;

   logic                            clk, reset_n, i_sdram_enable, i_tras_ok, i_b2x_req;
   logic [`SDR_DLY_W-1:0]           i_trp, i_trcar;
   logic [`SDR_ADDR_W-1:0]          i_mode_reg;
   logic [`SDR_RFSH_TIMER_W-1:0]    i_rfsh_time;
   logic [`SDR_RFSH_ROW_CNT_W-1:0]  i_rfsh_rmax;
   bank_req_t                       i_b2x;
   logic                            o_x2b_ack, o_refresh, o_act_ok, o_init_done;
   logic                            o_sdr_cs_n, o_sdr_ras_n, o_sdr_cas_n, o_sdr_we_n;
   logic [`SDR_BA_W-1:0]            o_sdr_ba;
   logic [`SDR_ADDR_W-1:0]          o_sdr_addr;
   int   n_err, n_refresh, n_mode, n_round, n_bank, round_refs;
   int   tb_err, tests_run, tests_failed, err_mark, sent, mark, guard;
   logic acked, tras_random;

   sdrc_mgmt_top UUT (.*);

   sdrc_cmd_model u_model (
      .clk(clk), .reset_n(reset_n), .i_tras_ok(i_tras_ok), .i_trp(i_trp),
      .i_trcar(i_trcar), .i_mode_reg(i_mode_reg), .i_rfsh_rmax(i_rfsh_rmax),
      .i_b2x(i_b2x), .i_x2b_ack(o_x2b_ack), .i_refresh(o_refresh), .i_act_ok(o_act_ok),
      .i_init_done(o_init_done), .i_sdr_cs_n(o_sdr_cs_n), .i_sdr_ras_n(o_sdr_ras_n),
      .i_sdr_cas_n(o_sdr_cas_n), .i_sdr_we_n(o_sdr_we_n), .i_sdr_ba(o_sdr_ba),
      .i_sdr_addr(o_sdr_addr), .o_n_err(n_err), .o_n_refresh(n_refresh),
      .o_n_mode(n_mode), .o_n_round(n_round), .o_n_bank(n_bank),
      .o_round_refs(round_refs));

   always #5 clk = ~clk;

   always @(posedge clk) begin
      #1;
      if (tras_random)
         i_tras_ok = ($urandom_range(0, 3) != 0);  // gaps of random length
   end

   function automatic int total_err();
      return tb_err + n_err;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic compare_int(input string sig, input int got, input int exp);
      assert (got == exp) else begin
         $display("ERR t=%0t %s got=%0d exp=%0d", $time, sig, got, exp);
         tb_err++;
      end
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (total_err() == err_mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, total_err() - err_mark);
      end
      err_mark = total_err();
   endtask

   // random request held until ack, then a random idle gap
   task automatic send_req(output logic got_ack);
      int         waited;
      logic [1:0] opv;
      opv          = 2'($urandom_range(0, 3));
      i_b2x.op     = bank_op_e'(opv);
      i_b2x.ba     = 2'($urandom_range(0, 3));
      i_b2x.addr   = 12'($urandom);
      i_b2x_req    = 1'b1;
      got_ack      = 1'b0;
      waited       = 0;
      while (!got_ack && waited < 300) begin
         @(negedge clk);
         got_ack = o_x2b_ack;
         tick();
         waited++;
      end
      i_b2x_req = 1'b0;
      if (!got_ack) begin
         $display("timeout: bank request at t=%0t was never acknowledged", $time);
         tb_err++;
      end
      repeat ($urandom_range(0, 3)) tick();
   endtask

   task automatic run_init();
      int ref0, mode0, waited;
      ref0           = n_refresh;
      mode0          = n_mode;
      i_trp          = 4'($urandom_range(1, 4));
      i_trcar        = 4'($urandom_range(2, 6));
      i_mode_reg     = 12'($urandom);
      i_sdram_enable = 1'b1;
      waited         = 0;
      while (!o_init_done && waited < 2000) begin
         tick();
         waited++;
      end
      if (!o_init_done) begin
         $display("timeout: init_done never rose after enable");
         tb_err++;
      end
      compare_int("init_refreshes", n_refresh - ref0, 15);
      compare_int("mode_commands", n_mode - mode0, 1);
   endtask

   initial begin
      void'($urandom(32'h957f));
      clk = 0;  reset_n = 0;  i_sdram_enable = 0;  i_tras_ok = 0;  tras_random = 0;
      i_trp = 4'd2;  i_trcar = 4'd3;  i_mode_reg = '0;
      i_rfsh_time = 12'hfff;  i_rfsh_rmax = 3'd7;              // no rounds early on
      i_b2x_req = 0;  i_b2x = '0;
      {tb_err, tests_run, tests_failed, err_mark} = '0;
      repeat (5) @(posedge clk);
      #1 reset_n = 1;
      tras_random = 1;
      err_mark = total_err();

      repeat (20) begin                        // requests before enable
         i_b2x_req = 1'($urandom_range(0, 1));
         i_b2x     = 16'($urandom);
         @(negedge clk);
         compare_int("o_x2b_ack", o_x2b_ack, 0);
         compare_int("o_init_done", o_init_done, 0);
         compare_int("o_sdr_cs_n", o_sdr_cs_n, 1);
         tick();
      end
      i_b2x_req = 0;
      end_test("1 idle before enable");

      run_init();
      end_test("2 init sequence");

      mark = n_bank;
      sent = 0;
      repeat (40) begin
         send_req(acked);
         if (acked)
            sent++;
      end
      tick();
      tick();
      compare_int("bank_commands", n_bank - mark, sent);
      end_test("3 bank requests");

      i_rfsh_rmax = 3'($urandom_range(1, 3));
      i_rfsh_time = 12'd40;
      mark  = n_round;
      guard = 0;
      while (n_round < mark + 3 && guard < 6000) begin
         send_req(acked);                      // ack must never land inside a round
         guard++;
      end
      if (n_round < mark + 3) begin
         $display("timeout: fewer than three refresh rounds were seen");
         tb_err++;
      end
      send_req(acked);                         // acked only once the round is over
      compare_int("round_refs", round_refs, i_rfsh_rmax);
      end_test("4 periodic refresh");

      i_rfsh_time = 12'hfff;
      send_req(acked);                         // sequencer sits in ACTIVE
      i_sdram_enable = 0;
      @(negedge clk);
      compare_int("o_init_done", o_init_done, 1);
      tick();
      @(negedge clk);
      compare_int("o_init_done", o_init_done, 0);
      repeat (10) tick();
      run_init();
      end_test("5 disable and re-init");

      $display("tests %0d run, %0d passed, %0d failed, %0d errors",
               tests_run, tests_run - tests_failed, tests_failed, total_err());
      if (tests_failed == 0 && total_err() == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   initial begin
      #2ms;
      $display("timeout: simulation ran past its time limit");
      $display("Result: FAILED");
      $finish;
   end

endmodule

/* source/sdrc_cfg.svh */
// widths, counts and fixed address encodings of the SDRAM management controller
`ifndef SDRC_CFG_SVH
`define SDRC_CFG_SVH

// SDRAM bus widths
`define SDR_ADDR_W          12        // row/column address
`define SDR_BA_W            2         // bank address

// management counters
`define SDR_DLY_W           4         // delay timer and refresh-count counter
`define SDR_RFSH_TIMER_W    12        // refresh interval timer
`define SDR_RFSH_ROW_CNT_W  3         // pending rows to refresh

// init sequence constants
`define SDR_INIT_REFRESHES  4'd15     // auto-refreshes before mode programming
`define SDR_TMRD            4'd7      // mode register to first command

// A10 high selects all banks on precharge
`define SDR_PRE_ALL_ADDR    12'h400

`endif

/* source/sdrc_cmd_arb.sv */
// management vs bank command arbitration, ack and refresh/activate status
`include "sdrc_cfg.svh"

module sdrc_cmd_arb (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  i_mgmt_req,
   input  sdrc_pkg::sdr_cmd_t    i_mgmt_cmd,
   input  logic                  i_init_done,
   input  logic                  i_b2x_req,
   input  sdrc_pkg::bank_req_t   i_b2x,
   output logic                  o_mgmt_ack,
   output logic                  o_x2b_ack,
   output sdrc_pkg::sdr_cmd_t    o_cmd,
   output logic                  o_refresh,
   output logic                  o_act_ok
);
   import sdrc_pkg::*;

   sdr_cmd_e b2x_cmd;      // decoded bank opcode
   logic     act_d1;       // activate one cycle ago
   logic     act_d2;       // and two

   always_comb begin
      case (i_b2x.op)
         OP_PRE:  b2x_cmd = PRECHARGE;
         OP_ACT:  b2x_cmd = ACTIVATE;
         OP_RD:   b2x_cmd = READ;
         OP_WR:   b2x_cmd = WRITE;
         default: b2x_cmd = DESEL;
      endcase
   end

   assign o_mgmt_ack = i_mgmt_req;                            // mgmt always wins
   assign o_x2b_ack  = i_b2x_req & ~i_mgmt_req & i_init_done;

   always_comb begin
      if (o_mgmt_ack) begin
         o_cmd = i_mgmt_cmd;
      end else if (o_x2b_ack) begin
         o_cmd.cmd  = b2x_cmd;
         o_cmd.ba   = i_b2x.ba;
         o_cmd.addr = i_b2x.addr;
      end else begin
         o_cmd.cmd  = DESEL;                                  // idle bus
         o_cmd.ba   = '0;
         o_cmd.addr = '0;
      end
   end

   assign o_refresh = (o_cmd.cmd == REFRESH);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         act_d1 <= 1'b0;
         act_d2 <= 1'b0;
      end else begin
         act_d1 <= (o_cmd.cmd == ACTIVATE);
         act_d2 <= act_d1;
      end
   end

   assign o_act_ok = ~act_d1 & ~act_d2;                       // tRRD spacing

endmodule

/* source/sdrc_init_fsm.sv */
// power-up initialization and periodic refresh state machine
`include "sdrc_cfg.svh"

module sdrc_init_fsm (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            i_sdram_enable,
   input  logic                            i_tras_ok,      // all banks past tRAS
   input  logic [`SDR_DLY_W-1:0]           i_trp,
   input  logic [`SDR_DLY_W-1:0]           i_trcar,
   input  logic [`SDR_ADDR_W-1:0]          i_mode_reg,
   input  logic                            i_mgmt_ack,
   input  logic                            i_dly_done,
   input  logic                            i_cnt_done,
   input  logic                            i_ref_req,
   input  logic [`SDR_RFSH_ROW_CNT_W-1:0]  i_row_cnt,
   output logic                            o_mgmt_req,
   output sdrc_pkg::sdr_cmd_t              o_mgmt_cmd,
   output logic                            o_ld_dly,
   output logic [`SDR_DLY_W-1:0]           o_dly_val,
   output logic                            o_ld_cnt,
   output logic [`SDR_DLY_W-1:0]           o_cnt_val,
   output logic                            o_dec_cnt,
   output logic                            o_in_active,
   output logic                            o_init_done
);
   import sdrc_pkg::*;

   mgmt_state_e state, next_state;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state       <= MGM_POWERUP;
         o_init_done <= 1'b0;
      end else begin
         state       <= next_state;
         o_init_done <= (o_in_active | o_init_done) & i_sdram_enable; // sticky until disable
      end
   end

   assign o_in_active = (state == MGM_ACTIVE);

   always_comb begin
      next_state      = state;
      o_mgmt_req      = 1'b1;              // held through the whole sequence
      o_mgmt_cmd.cmd  = DESEL;
      o_mgmt_cmd.ba   = '0;
      o_mgmt_cmd.addr = `SDR_PRE_ALL_ADDR;
      o_ld_dly        = 1'b0;
      o_dly_val       = i_trp;
      o_ld_cnt        = 1'b0;
      o_cnt_val       = `SDR_INIT_REFRESHES;
      o_dec_cnt       = 1'b0;
      case (state)
         MGM_POWERUP: begin
            o_mgmt_req = 1'b0;
            o_ld_cnt   = 1'b1;                       // arm init refresh count
            if (i_sdram_enable)
               next_state = MGM_PRECHARGE;
         end
         MGM_PRECHARGE: begin
            if (i_tras_ok) begin                     // wait out tRAS
               o_mgmt_cmd.cmd = PRECHARGE;           // all banks
               o_ld_dly       = i_mgmt_ack;          // trp
               if (i_mgmt_ack)
                  next_state = MGM_PCHWT;
            end
         end
         MGM_PCHWT: begin
            if (i_dly_done)
               next_state = MGM_REFRESH;
         end
         MGM_REFRESH: begin
            o_mgmt_cmd.cmd = REFRESH;
            o_ld_dly       = i_mgmt_ack;
            o_dly_val      = i_trcar;
            o_dec_cnt      = i_mgmt_ack;
            if (i_mgmt_ack)
               next_state = MGM_REFWT;
         end
         MGM_REFWT: begin
            if (i_dly_done) begin
               if (!i_cnt_done)
                  next_state = MGM_REFRESH;          // more rows to go
               else if (o_init_done)
                  next_state = MGM_ACTIVE;           // periodic round, no mode
               else
                  next_state = MGM_MODE_REG;
            end
         end
         MGM_MODE_REG: begin
            o_mgmt_cmd.cmd   = MODE;
            o_mgmt_cmd.ba[0] = i_mode_reg[11];       // ba = {0, mode[11]}
            o_mgmt_cmd.addr  = i_mode_reg;
            o_ld_dly         = i_mgmt_ack;
            o_dly_val        = `SDR_TMRD;
            if (i_mgmt_ack)
               next_state = MGM_MODE_WT;
         end
         MGM_MODE_WT: begin
            if (i_dly_done)
               next_state = MGM_ACTIVE;
         end
         MGM_ACTIVE: begin
            o_mgmt_req = 1'b0;                       // bank side owns the bus
            o_ld_cnt   = i_ref_req;
            o_cnt_val  = '0;
            o_cnt_val[`SDR_RFSH_ROW_CNT_W-1:0] = i_row_cnt; // refresh all pending rows
            if (!i_sdram_enable)
               next_state = MGM_POWERUP;
            else if (i_ref_req)
               next_state = MGM_PRECHARGE;
         end
         default: next_state = MGM_POWERUP;
      endcase
   end

   // a real command may only go out once the previous wait has expired
   a_no_cmd_in_wait: assert property (@(posedge clk) disable iff (!reset_n)
      (o_mgmt_req && !i_dly_done) |-> (o_mgmt_cmd.cmd == DESEL));

endmodule

/* source/sdrc_mgmt_timer.sv */
// delay timer, refresh-count counter, refresh interval timer and row counter
`include "sdrc_cfg.svh"

module sdrc_mgmt_timer (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            i_ld_dly,
   input  logic [`SDR_DLY_W-1:0]           i_dly_val,
   input  logic                            i_ld_cnt,
   input  logic [`SDR_DLY_W-1:0]           i_cnt_val,
   input  logic                            i_dec_cnt,
   input  logic                            i_in_active,
   input  logic [`SDR_RFSH_TIMER_W-1:0]    i_rfsh_time,   // cycles per row
   input  logic [`SDR_RFSH_ROW_CNT_W-1:0]  i_rfsh_rmax,   // rows per round
   output logic                            o_dly_done,
   output logic                            o_cnt_done,
   output logic                            o_ref_req,
   output logic [`SDR_RFSH_ROW_CNT_W-1:0]  o_row_cnt
);

   logic [`SDR_DLY_W-1:0]        dly;          // counts down to zero and sticks
   logic [`SDR_DLY_W-1:0]        cnt;          // refreshes left in this round
   logic [`SDR_RFSH_TIMER_W-1:0] rfsh_timer;   // free running
   logic                         rfsh_tc;

   assign o_dly_done = (dly == '0);
   assign o_cnt_done = (cnt == '0);
   assign rfsh_tc    = (rfsh_timer == i_rfsh_time);
   assign o_ref_req  = (o_row_cnt >= i_rfsh_rmax);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         dly        <= '0;
         cnt        <= `SDR_INIT_REFRESHES;
         rfsh_timer <= '0;
         o_row_cnt  <= '0;
      end else begin
         if (i_ld_dly)
            dly <= i_dly_val;
         else if (!o_dly_done)
            dly <= dly - 1'b1;
         if (i_ld_cnt)
            cnt <= i_cnt_val;
         else if (i_dec_cnt)
            cnt <= cnt - 1'b1;                 // one per refresh issued
         rfsh_timer <= rfsh_tc ? '0 : rfsh_timer + 1'b1; // 0..rfsh_time
         if (!i_in_active)
            o_row_cnt <= '0;                   // cleared once a round starts
         else if (rfsh_tc)
            o_row_cnt <= o_row_cnt + 1'b1;
      end
   end

   // the sequencer must stop issuing refreshes once the count is used up
   a_no_cnt_underflow: assert property (@(posedge clk) disable iff (!reset_n)
      i_dec_cnt |-> !o_cnt_done);

endmodule

/* source/sdrc_mgmt_top.sv */
// top level of the SDRAM init/refresh controller and command pin path
`include "sdrc_cfg.svh"

module sdrc_mgmt_top (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            i_sdram_enable,
   input  logic                            i_tras_ok,
   input  logic [`SDR_DLY_W-1:0]           i_trp,
   input  logic [`SDR_DLY_W-1:0]           i_trcar,
   input  logic [`SDR_ADDR_W-1:0]          i_mode_reg,
   input  logic [`SDR_RFSH_TIMER_W-1:0]    i_rfsh_time,
   input  logic [`SDR_RFSH_ROW_CNT_W-1:0]  i_rfsh_rmax,
   input  logic                            i_b2x_req,
   input  sdrc_pkg::bank_req_t             i_b2x,
   output logic                            o_x2b_ack,
   output logic                            o_refresh,
   output logic                            o_act_ok,
   output logic                            o_init_done,
   output logic                            o_sdr_cs_n,
   output logic                            o_sdr_ras_n,
   output logic                            o_sdr_cas_n,
   output logic                            o_sdr_we_n,
   output logic [`SDR_BA_W-1:0]            o_sdr_ba,
   output logic [`SDR_ADDR_W-1:0]          o_sdr_addr
);
   import sdrc_pkg::*;

   logic                            mgmt_req, mgmt_ack;
   sdr_cmd_t                        mgmt_cmd, sel_cmd;   // fsm request, arbitrated result
   logic                            ld_dly, ld_cnt, dec_cnt, in_active;
   logic [`SDR_DLY_W-1:0]           dly_val, cnt_val;
   logic                            dly_done, cnt_done, ref_req;
   logic [`SDR_RFSH_ROW_CNT_W-1:0]  row_cnt;

   sdrc_init_fsm u_init_fsm (
      .clk(clk), .reset_n(reset_n), .i_sdram_enable(i_sdram_enable),
      .i_tras_ok(i_tras_ok), .i_trp(i_trp), .i_trcar(i_trcar), .i_mode_reg(i_mode_reg),
      .i_mgmt_ack(mgmt_ack), .i_dly_done(dly_done), .i_cnt_done(cnt_done),
      .i_ref_req(ref_req), .i_row_cnt(row_cnt), .o_mgmt_req(mgmt_req),
      .o_mgmt_cmd(mgmt_cmd), .o_ld_dly(ld_dly), .o_dly_val(dly_val), .o_ld_cnt(ld_cnt),
      .o_cnt_val(cnt_val), .o_dec_cnt(dec_cnt), .o_in_active(in_active),
      .o_init_done(o_init_done));

   sdrc_mgmt_timer u_timer (
      .clk(clk), .reset_n(reset_n), .i_ld_dly(ld_dly), .i_dly_val(dly_val),
      .i_ld_cnt(ld_cnt), .i_cnt_val(cnt_val), .i_dec_cnt(dec_cnt), .i_in_active(in_active),
      .i_rfsh_time(i_rfsh_time), .i_rfsh_rmax(i_rfsh_rmax), .o_dly_done(dly_done),
      .o_cnt_done(cnt_done), .o_ref_req(ref_req), .o_row_cnt(row_cnt));

   sdrc_cmd_arb u_arb (
      .clk(clk), .reset_n(reset_n), .i_mgmt_req(mgmt_req), .i_mgmt_cmd(mgmt_cmd),
      .i_init_done(o_init_done), .i_b2x_req(i_b2x_req), .i_b2x(i_b2x),
      .o_mgmt_ack(mgmt_ack), .o_x2b_ack(o_x2b_ack), .o_cmd(sel_cmd),
      .o_refresh(o_refresh), .o_act_ok(o_act_ok));

   sdrc_sdr_io u_io (
      .clk(clk), .reset_n(reset_n), .i_cmd(sel_cmd), .o_sdr_cs_n(o_sdr_cs_n),
      .o_sdr_ras_n(o_sdr_ras_n), .o_sdr_cas_n(o_sdr_cas_n), .o_sdr_we_n(o_sdr_we_n),
      .o_sdr_ba(o_sdr_ba), .o_sdr_addr(o_sdr_addr));

endmodule

/* source/sdrc_pkg.sv */
// command, opcode and state enums, bank request and SDRAM command structs
`include "sdrc_cfg.svh"

package sdrc_pkg;

   // {cs_n, ras_n, cas_n, we_n}
   typedef enum logic [3:0] {
      DESEL      = 4'b1111,           // chip not selected
      NOP        = 4'b0111,
      ACTIVATE   = 4'b0011,
      READ       = 4'b0101,
      WRITE      = 4'b0100,
      BURST_STOP = 4'b0110,
      PRECHARGE  = 4'b0010,
      REFRESH    = 4'b0001,
      MODE       = 4'b0000            // load mode register
   } sdr_cmd_e;

   // opcodes from the bank controller
   typedef enum logic [1:0] {
      OP_PRE = 2'b00,
      OP_ACT = 2'b01,
      OP_RD  = 2'b10,
      OP_WR  = 2'b11
   } bank_op_e;

   // init / refresh sequencer states
   typedef enum logic [2:0] {
      MGM_POWERUP   = 3'b000,
      MGM_PRECHARGE = 3'b001,
      MGM_PCHWT     = 3'b010,
      MGM_REFRESH   = 3'b011,
      MGM_REFWT     = 3'b100,
      MGM_MODE_REG  = 3'b101,
      MGM_MODE_WT   = 3'b110,
      MGM_ACTIVE    = 3'b111
   } mgmt_state_e;

   typedef struct packed {
      bank_op_e                op;    // what to issue
      logic [`SDR_BA_W-1:0]    ba;
      logic [`SDR_ADDR_W-1:0]  addr;  // row for activate, column otherwise
   } bank_req_t;

   typedef struct packed {
      sdr_cmd_e                cmd;
      logic [`SDR_BA_W-1:0]    ba;
      logic [`SDR_ADDR_W-1:0]  addr;
   } sdr_cmd_t;

endpackage

/* source/sdrc_sdr_io.sv */
// SDRAM command, bank and address pin registers
`include "sdrc_cfg.svh"

module sdrc_sdr_io (
   input  logic                    clk,
   input  logic                    reset_n,
   input  sdrc_pkg::sdr_cmd_t      i_cmd,
   output logic                    o_sdr_cs_n,
   output logic                    o_sdr_ras_n,
   output logic                    o_sdr_cas_n,
   output logic                    o_sdr_we_n,
   output logic [`SDR_BA_W-1:0]    o_sdr_ba,
   output logic [`SDR_ADDR_W-1:0]  o_sdr_addr
);
   import sdrc_pkg::*;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_sdr_cs_n  <= 1'b1;                  // deselected
         o_sdr_ras_n <= 1'b1;
         o_sdr_cas_n <= 1'b1;
         o_sdr_we_n  <= 1'b1;
      end else begin
         o_sdr_cs_n  <= i_cmd.cmd[3];
         o_sdr_ras_n <= i_cmd.cmd[2];
         o_sdr_cas_n <= i_cmd.cmd[1];
         o_sdr_we_n  <= i_cmd.cmd[0];
      end
   end

   // address only moves with a selected command
   always_ff @(posedge clk) begin
      if (i_cmd.cmd[3] == 1'b0) begin
         o_sdr_ba   <= i_cmd.ba;
         o_sdr_addr <= i_cmd.addr;
      end
   end

   // pins idle through reset and the first command slot after it
   a_strobes_idle_in_reset: assert property (@(posedge clk)
      !reset_n |=> (o_sdr_cs_n && o_sdr_ras_n && o_sdr_cas_n && o_sdr_we_n) [*2]);

endmodule
